/* mem_stage_pkg.sv */
// Widths and codes are fixed for a 4-lane, 32-bit element machine
// Stores are word-only, so there are no store size codes
package mem_stage_pkg;

    localparam int num_lanes = 4;

    typedef logic [31:0]                  word_t;      // Data word or byte address
    typedef logic [num_lanes-1:0]         lane_mask_t;
    typedef logic [$clog2(num_lanes)-1:0] lane_idx_t;

    // Load types follow the RV32 funct3 encoding
    typedef logic [2:0] load_type_t;
    localparam load_type_t ld_lb  = 3'b000;
    localparam load_type_t ld_lh  = 3'b001;
    localparam load_type_t ld_lw  = 3'b010;
    localparam load_type_t ld_lbu = 3'b100;
    localparam load_type_t ld_lhu = 3'b101;

    // Vector addressing modes, code 3 is unused
    typedef logic [1:0] vaddr_mode_t;
    localparam vaddr_mode_t vm_unit    = 2'd0;
    localparam vaddr_mode_t vm_strided = 2'd1;
    localparam vaddr_mode_t vm_indexed = 2'd2;

    typedef enum logic [1:0] {
        vs_idle,
        vs_issue,   // First cycle of a lane request
        vs_wait,    // Request held until done
        vs_done
    } vser_state_t;

    typedef enum logic {
        ls_idle,
        ls_busy
    } lsc_state_t;

endpackage

/* lsc_if.sv */
// One word request and its result; ren/wen held until done pulses
// done and load_data are combinational from the bus in the completing cycle
`timescale 1ns/10ps

interface lsc_if;

    logic                       ren;
    logic                       wen;
    mem_stage_pkg::word_t       addr;
    mem_stage_pkg::word_t       store_data;
    mem_stage_pkg::load_type_t  load_type;
    logic                       done;        // One cycle per access
    mem_stage_pkg::word_t       load_data;   // Extended load result

    modport req (
        output ren, wen, addr, store_data, load_type,
        input  done, load_data
    );

    modport ctrl (
        input  ren, wen, addr, store_data, load_type,
        output done, load_data
    );

endinterface

/* vmem_serializer.sv */
// vstart is only taken while idle; operands are sampled on that pulse
// Lanes are walked in order 0 to 3, masked-off lanes cost nothing
`timescale 1ns/10ps

module vmem_serializer (
    input  logic                                                   CLK,
    input  logic                                                   rst_n,
    input  logic                                                   vstart,
    input  logic                                                   vload,
    input  logic                                                   vstore,
    input  mem_stage_pkg::vaddr_mode_t                             vmode,
    input  mem_stage_pkg::word_t                                   vbase,
    input  mem_stage_pkg::word_t                                   vstride,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]    vindex,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]    vstore_data,
    input  mem_stage_pkg::lane_mask_t                              vlane_mask,
    input  logic                                                   vreq_done,
    output logic                                                   vreq_ren,
    output logic                                                   vreq_wen,
    output mem_stage_pkg::word_t                                   vreq_addr,
    output mem_stage_pkg::word_t                                   vreq_data,
    output mem_stage_pkg::lane_idx_t                               cur_lane,
    output logic                                                   busy,
    output logic                                                   vdone
);

    mem_stage_pkg::vser_state_t                           state;
    mem_stage_pkg::lane_mask_t                            pend_mask;   // Lanes still to access
    mem_stage_pkg::lane_mask_t                            pend_left;
    logic                                                 is_load;
    logic                                                 is_store;
    logic                                                 req_active;
    mem_stage_pkg::vaddr_mode_t                           mode_q;
    mem_stage_pkg::word_t                                 base_q;
    mem_stage_pkg::word_t                                 stride_q;
    mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  index_q;
    mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  data_q;

    // Lowest set lane of a mask
    function automatic mem_stage_pkg::lane_idx_t first_lane(input mem_stage_pkg::lane_mask_t m);
        mem_stage_pkg::lane_idx_t idx;
        idx = '0;
        for (int i = mem_stage_pkg::num_lanes - 1; i >= 0; i--) begin
            if (m[i]) idx = mem_stage_pkg::lane_idx_t'(i);
        end
        return idx;
    endfunction

    assign pend_left = pend_mask & ~(mem_stage_pkg::lane_mask_t'(1) << cur_lane);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= mem_stage_pkg::vs_idle;
            pend_mask <= '0;
            cur_lane  <= '0;
            is_load   <= 1'b0;
            is_store  <= 1'b0;
        end else begin
            case (state)
                mem_stage_pkg::vs_idle: if (vstart) begin
                    is_load   <= vload;
                    is_store  <= vstore;
                    pend_mask <= vlane_mask;
                    cur_lane  <= first_lane(vlane_mask);
                    state     <= (vlane_mask == '0) ? mem_stage_pkg::vs_done
                                                    : mem_stage_pkg::vs_issue;
                end
                mem_stage_pkg::vs_issue: state <= mem_stage_pkg::vs_wait;
                mem_stage_pkg::vs_wait: if (vreq_done) begin
                    pend_mask <= pend_left;
                    if (pend_left == '0) begin
                        state <= mem_stage_pkg::vs_done;
                    end else begin
                        cur_lane <= first_lane(pend_left);   // Skip masked lanes
                        state    <= mem_stage_pkg::vs_issue;
                    end
                end
                default: state <= mem_stage_pkg::vs_idle;   // vs_done lasts one cycle
            endcase
        end
    end

    // Operand capture
    always_ff @(posedge CLK) begin
        if (vstart && state == mem_stage_pkg::vs_idle) begin
            mode_q   <= vmode;
            base_q   <= vbase;
            stride_q <= vstride;
            index_q  <= vindex;
            data_q   <= vstore_data;
        end
    end

    always_comb begin
        case (mode_q)
            mem_stage_pkg::vm_strided:
                vreq_addr = base_q + stride_q * mem_stage_pkg::word_t'(cur_lane);
            mem_stage_pkg::vm_indexed:
                vreq_addr = base_q + index_q[cur_lane];
            default:
                vreq_addr = base_q + (mem_stage_pkg::word_t'(cur_lane) << 2);   // Unit stride
        endcase
    end

    assign req_active = (state == mem_stage_pkg::vs_issue) || (state == mem_stage_pkg::vs_wait);
    assign vreq_ren   = req_active & is_load;
    assign vreq_wen   = req_active & is_store;
    assign vreq_data  = data_q[cur_lane];
    assign busy       = vstart | (state != mem_stage_pkg::vs_idle);   // Also the stall
    assign vdone      = (state == mem_stage_pkg::vs_done);

endmodule

/* mem_req_arbiter.sv */
// Serializer wins whenever busy; an access in flight keeps its owner
`timescale 1ns/10ps

module mem_req_arbiter (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       busy,
    input  logic                       vreq_ren,
    input  logic                       vreq_wen,
    input  mem_stage_pkg::word_t       vreq_addr,
    input  mem_stage_pkg::word_t       vreq_data,
    input  logic                       scalar_ren,
    input  logic                       scalar_wen,
    input  mem_stage_pkg::word_t       scalar_addr,
    input  mem_stage_pkg::word_t       scalar_wdata,
    input  mem_stage_pkg::load_type_t  scalar_load_type,
    output logic                       vreq_done,
    output logic                       scalar_done,
    output mem_stage_pkg::word_t       scalar_rdata,
    output mem_stage_pkg::word_t       lane_rdata,
    lsc_if.req                         lsc
);

    logic active;      // Access accepted, waiting for done
    logic grant_vec;   // Owner of the access in flight
    logic use_vec;

    assign use_vec = active ? grant_vec : busy;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            active    <= 1'b0;
            grant_vec <= 1'b0;
        end else if (lsc.done) begin
            active <= 1'b0;
        end else if (!active && (lsc.ren || lsc.wen)) begin
            active    <= 1'b1;
            grant_vec <= use_vec;
        end
    end

    assign lsc.ren        = use_vec ? vreq_ren  : scalar_ren;
    assign lsc.wen        = use_vec ? vreq_wen  : scalar_wen;
    assign lsc.addr       = use_vec ? vreq_addr : scalar_addr;
    assign lsc.store_data = use_vec ? vreq_data : scalar_wdata;
    assign lsc.load_type  = use_vec ? mem_stage_pkg::ld_lw : scalar_load_type;   // Lanes are words

    assign vreq_done    = lsc.done & use_vec;
    assign scalar_done  = lsc.done & ~use_vec;
    assign scalar_rdata = lsc.load_data;
    assign lane_rdata   = lsc.load_data;

endmodule

/* load_store_ctrl.sv */
// Registers one request onto the bus and holds it through busy
// Word stores only; a misaligned half load reads the half at addr[1]
`timescale 1ns/10ps

module load_store_ctrl (
    input  logic                  CLK,
    input  logic                  rst_n,
    lsc_if.ctrl                   lsc,
    input  mem_stage_pkg::word_t  dbus_rdata,
    input  logic                  dbus_busy,
    output logic                  dbus_ren,
    output logic                  dbus_wen,
    output mem_stage_pkg::word_t  dbus_addr,
    output mem_stage_pkg::word_t  dbus_wdata
);

    mem_stage_pkg::lsc_state_t  state;
    mem_stage_pkg::load_type_t  type_q;
    logic [7:0]                 ld_byte;
    logic [15:0]                ld_half;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state    <= mem_stage_pkg::ls_idle;
            dbus_ren <= 1'b0;
            dbus_wen <= 1'b0;
        end else begin
            case (state)
                mem_stage_pkg::ls_idle: if (lsc.ren || lsc.wen) begin
                    dbus_ren <= lsc.ren;
                    dbus_wen <= lsc.wen & ~lsc.ren;   // Load wins a bad double strobe
                    state    <= mem_stage_pkg::ls_busy;
                end
                default: if (!dbus_busy) begin
                    dbus_ren <= 1'b0;
                    dbus_wen <= 1'b0;
                    state    <= mem_stage_pkg::ls_idle;
                end
            endcase
        end
    end

    // Address and data held for the whole access
    always_ff @(posedge CLK) begin
        if (state == mem_stage_pkg::ls_idle && (lsc.ren || lsc.wen)) begin
            dbus_addr  <= lsc.addr;
            dbus_wdata <= lsc.store_data;
            type_q     <= lsc.load_type;
        end
    end

    // Completes in the first cycle on the bus without busy
    assign lsc.done = (state == mem_stage_pkg::ls_busy) && !dbus_busy;

    always_comb begin
        ld_byte = dbus_rdata[{dbus_addr[1:0], 3'b000} +: 8];
        ld_half = dbus_addr[1] ? dbus_rdata[31:16] : dbus_rdata[15:0];
        case (type_q)
            mem_stage_pkg::ld_lb:  lsc.load_data = {{24{ld_byte[7]}}, ld_byte};
            mem_stage_pkg::ld_lbu: lsc.load_data = {24'h0, ld_byte};
            mem_stage_pkg::ld_lh:  lsc.load_data = {{16{ld_half[15]}}, ld_half};
            mem_stage_pkg::ld_lhu: lsc.load_data = {16'h0, ld_half};
            default:               lsc.load_data = dbus_rdata;   // lw
        endcase
    end

endmodule

/* vlane_write_collect.sv */
// Expects vstart only while the serializer is idle
`timescale 1ns/10ps

module vlane_write_collect (
    input  logic                                                 CLK,
    input  logic                                                 rst_n,
    input  logic                                                 vstart,
    input  logic                                                 vload,
    input  mem_stage_pkg::lane_idx_t                             cur_lane,
    input  mem_stage_pkg::word_t                                 lane_rdata,
    input  logic                                                 vreq_done,
    input  logic                                                 vdone,
    output mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vwb_data,
    output mem_stage_pkg::lane_mask_t                            vwb_wen
);

    logic                       load_op;   // Current vector op is a load
    mem_stage_pkg::lane_mask_t  wen_q;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            load_op <= 1'b0;
            wen_q   <= '0;
        end else if (vstart) begin
            load_op <= vload;
            wen_q   <= '0;
        end else if (vreq_done && load_op) begin
            wen_q[cur_lane] <= 1'b1;
        end
    end

    // Lane words, held until the next load overwrites them
    always_ff @(posedge CLK) begin
        if (vreq_done && load_op) begin
            vwb_data[cur_lane] <= lane_rdata;
        end
    end

    assign vwb_wen = vdone ? wen_q : '0;   // Only in the vdone cycle

endmodule

/* mem_stage.sv */
// Memory stage top: scalar path and vector serializer share one data bus
// Bus access completes in the first cycle with a strobe high and busy low
`timescale 1ns/10ps

module mem_stage (
    input  logic                                                 CLK,
    input  logic                                                 rst_n,
    input  logic                                                 scalar_ren,
    input  logic                                                 scalar_wen,
    input  mem_stage_pkg::word_t                                 scalar_addr,
    input  mem_stage_pkg::word_t                                 scalar_wdata,
    input  mem_stage_pkg::load_type_t                            scalar_load_type,
    output logic                                                 scalar_done,
    output mem_stage_pkg::word_t                                 scalar_rdata,
    input  logic                                                 vstart,
    input  logic                                                 vload,
    input  logic                                                 vstore,
    input  mem_stage_pkg::vaddr_mode_t                           vmode,
    input  mem_stage_pkg::word_t                                 vbase,
    input  mem_stage_pkg::word_t                                 vstride,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vindex,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vstore_data,
    input  mem_stage_pkg::lane_mask_t                            vlane_mask,
    output logic                                                 vdone,
    output logic                                                 mem_stall,
    output mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vwb_data,
    output mem_stage_pkg::lane_mask_t                            vwb_wen,
    output logic                                                 dbus_ren,
    output logic                                                 dbus_wen,
    output mem_stage_pkg::word_t                                 dbus_addr,
    output mem_stage_pkg::word_t                                 dbus_wdata,
    input  mem_stage_pkg::word_t                                 dbus_rdata,
    input  logic                                                 dbus_busy
);

    logic                       vreq_ren;
    logic                       vreq_wen;
    mem_stage_pkg::word_t       vreq_addr;
    mem_stage_pkg::word_t       vreq_data;
    logic                       vreq_done;
    mem_stage_pkg::lane_idx_t   cur_lane;
    mem_stage_pkg::word_t       lane_rdata;

    lsc_if lsc_bus ();

    // Serializer busy doubles as the pipeline stall
    vmem_serializer ser_i (
        .CLK, .rst_n, .vstart, .vload, .vstore, .vmode, .vbase, .vstride,
        .vindex, .vstore_data, .vlane_mask, .vreq_done,
        .vreq_ren, .vreq_wen, .vreq_addr, .vreq_data, .cur_lane,
        .busy(mem_stall), .vdone
    );

    mem_req_arbiter arb_i (
        .CLK, .rst_n, .busy(mem_stall),
        .vreq_ren, .vreq_wen, .vreq_addr, .vreq_data,
        .scalar_ren, .scalar_wen, .scalar_addr, .scalar_wdata, .scalar_load_type,
        .vreq_done, .scalar_done, .scalar_rdata, .lane_rdata,
        .lsc(lsc_bus)
    );

    load_store_ctrl lsc_i (
        .CLK, .rst_n, .lsc(lsc_bus), .dbus_rdata, .dbus_busy,
        .dbus_ren, .dbus_wen, .dbus_addr, .dbus_wdata
    );

    vlane_write_collect wbc_i (
        .CLK, .rst_n, .vstart, .vload, .cur_lane, .lane_rdata,
        .vreq_done, .vdone, .vwb_data, .vwb_wen
    );

endmodule

/* mem_stage_asserts.sv */
// Bus and done timing rules, bound into mem_stage
// fails counts assertion failures for the testbench summary
`timescale 1ns/10ps

module mem_stage_asserts (
    input logic                 CLK,
    input logic                 rst_n,
    input logic                 dbus_ren,
    input logic                 dbus_wen,
    input logic                 dbus_busy,
    input mem_stage_pkg::word_t dbus_addr,
    input logic                 scalar_done,
    input logic                 vdone,
    input logic                 mem_stall
);

    int fails = 0;

    a_strobe_excl: assert property (@(posedge CLK) disable iff (!rst_n) !(dbus_ren && dbus_wen))
        else begin $error("dbus_ren and dbus_wen high together"); fails++; end
    a_sdone_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
        scalar_done |=> !scalar_done)
        else begin $error("scalar_done longer than one cycle"); fails++; end
    a_vdone_pulse: assert property (@(posedge CLK) disable iff (!rst_n) vdone |=> !vdone)
        else begin $error("vdone longer than one cycle"); fails++; end
    a_addr_stable: assert property (@(posedge CLK) disable iff (!rst_n)
        (dbus_ren || dbus_wen) && dbus_busy |=> $stable(dbus_addr))
        else begin $error("dbus_addr changed while busy"); fails++; end
    a_stall_reset: assert property (@(posedge CLK) $rose(rst_n) |-> !mem_stall)
        else begin $error("mem_stall high after reset"); fails++; end

endmodule

/* mem_stage_checker.sv */
// Watches the DUT at the falling edge; reference memory starts with the testbench fill
// Only the low 64 words are modeled, addresses wrap
`timescale 1ns/10ps

module mem_stage_checker (
    input  logic                                                 CLK,
    input  logic                                                 scalar_ren,
    input  logic                                                 scalar_wen,
    input  mem_stage_pkg::word_t                                 scalar_addr,
    input  mem_stage_pkg::word_t                                 scalar_wdata,
    input  mem_stage_pkg::load_type_t                            scalar_load_type,
    input  logic                                                 scalar_done,
    input  mem_stage_pkg::word_t                                 scalar_rdata,
    input  logic                                                 vstart,
    input  logic                                                 vload,
    input  mem_stage_pkg::vaddr_mode_t                           vmode,
    input  mem_stage_pkg::word_t                                 vbase,
    input  mem_stage_pkg::word_t                                 vstride,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vindex,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vstore_data,
    input  mem_stage_pkg::lane_mask_t                            vlane_mask,
    input  logic                                                 vdone,
    input  logic                                                 mem_stall,
    input  mem_stage_pkg::word_t [mem_stage_pkg::num_lanes-1:0]  vwb_data,
    input  mem_stage_pkg::lane_mask_t                            vwb_wen,
    input  logic                                                 dbus_ren,
    input  logic                                                 dbus_wen,
    output int                                                   checks,
    output int                                                   errors
);

    mem_stage_pkg::word_t ref_mem [64];
    logic sc_pend = 1'b0;
    logic vec_pend = 1'b0;
    logic sc_ld;
    logic v_ld;
    logic bus_seen;
    int   sc_wait;
    int   v_wait;
    mem_stage_pkg::word_t s_addr, s_data, v_base, v_stride;
    mem_stage_pkg::load_type_t s_lt;
    mem_stage_pkg::vaddr_mode_t v_mode;
    mem_stage_pkg::lane_mask_t v_mask;
    mem_stage_pkg::word_t [3:0] v_idx, v_data;

    initial begin
        checks = 0;
        errors = 0;
        for (int i = 0; i < 64; i++) ref_mem[i] = (i * 32'h9e37_79b9) ^ {i[7:0], 24'h5a00c3};
    end

    // Expected load result from the RV32 load rules
    function automatic mem_stage_pkg::word_t extend(input mem_stage_pkg::word_t w,
            input mem_stage_pkg::load_type_t lt, input logic [1:0] off);
        logic [31:0] b;
        logic [31:0] h;
        b = w >> (8 * off);
        h = w >> (16 * off[1]);
        case (lt)
            mem_stage_pkg::ld_lb:  return {{24{b[7]}}, b[7:0]};
            mem_stage_pkg::ld_lbu: return {24'h0, b[7:0]};
            mem_stage_pkg::ld_lh:  return {{16{h[15]}}, h[15:0]};
            mem_stage_pkg::ld_lhu: return {16'h0, h[15:0]};
            default:               return w;
        endcase
    endfunction

    function automatic int lane_word(input int l);
        mem_stage_pkg::word_t a;
        if (v_mode == mem_stage_pkg::vm_strided) a = v_base + v_stride * l;
        else if (v_mode == mem_stage_pkg::vm_indexed) a = v_base + v_idx[l];
        else a = v_base + 4 * l;
        return a[7:2];
    endfunction

    task automatic result(input string what, input logic ok);
        checks++;
        if (!ok) errors++;
        $display("Test %0d %s: %s", checks, what, ok ? "ok" : "FAILED");
    endtask

    always @(negedge CLK) begin
        mem_stage_pkg::word_t exp_w;
        mem_stage_pkg::lane_mask_t exp_en;
        logic ok;
        if (!sc_pend && (scalar_ren || scalar_wen)) begin
            {sc_pend, sc_ld, sc_wait} = {1'b1, scalar_ren, 32'd0};
            {s_addr, s_data, s_lt} = {scalar_addr, scalar_wdata, scalar_load_type};
        end else if (sc_pend && scalar_done) begin
            sc_pend = 1'b0;
            ok = !vec_pend;
            if (vec_pend) $display("Error: scalar access completed during a vector operation");
            if (sc_ld) begin
                exp_w = extend(ref_mem[s_addr[7:2]], s_lt, s_addr[1:0]);
                if (scalar_rdata !== exp_w) begin
                    $display("Mismatch at %0t: scalar load %h type %0d got %h expected %h",
                             $time, s_addr, s_lt, scalar_rdata, exp_w);
                    ok = 1'b0;
                end
            end else begin
                ref_mem[s_addr[7:2]] = s_data;
            end
            result(sc_ld ? "scalar load" : "scalar store", ok);
        end else if (sc_pend) begin
            sc_wait++;
            if (sc_wait > 60) begin
                sc_pend = 1'b0;
                $display("Error: scalar request at %h never got scalar_done", s_addr);
                result("scalar access", 1'b0);
            end
        end

        if (vstart) begin
            {vec_pend, v_ld, bus_seen, v_wait} = {1'b1, vload, 1'b0, 32'd0};
            {v_mode, v_base, v_stride, v_mask} = {vmode, vbase, vstride, vlane_mask};
            {v_idx, v_data} = {vindex, vstore_data};
        end
        if (vec_pend) begin
            bus_seen = bus_seen | dbus_ren | dbus_wen;
            if (!mem_stall) begin
                $display("Mismatch at %0t: mem_stall low during a vector operation", $time);
                errors++;
            end
            if (vdone) begin
                vec_pend = 1'b0;
                ok = !(v_mask == '0 && bus_seen);
                if (!ok) $display("Error: bus access seen for an all-zero lane mask");
                exp_en = v_ld ? v_mask : '0;
                if (vwb_wen !== exp_en) begin
                    $display("Mismatch at %0t: vwb_wen %b expected %b", $time, vwb_wen, exp_en);
                    ok = 1'b0;
                end
                for (int l = 0; l < 4; l++) begin
                    if (v_mask[l] && !v_ld) ref_mem[lane_word(l)] = v_data[l];
                    if (v_mask[l] && v_ld && vwb_data[l] !== ref_mem[lane_word(l)]) begin
                        $display("Mismatch at %0t: lane %0d got %h expected %h", $time, l,
                                 vwb_data[l], ref_mem[lane_word(l)]);
                        ok = 1'b0;
                    end
                end
                result(v_ld ? "vector load" : "vector store", ok);
            end else begin
                v_wait++;
                if (v_wait > 60) begin
                    vec_pend = 1'b0;
                    $display("Error: vector operation never got vdone");
                    result("vector operation", 1'b0);
                end
            end
        end
    end

endmodule

/* mem_stage_tb.sv */
// Memory model answers the data bus with 0 to 2 random busy cycles per access
// Only 64 words are modeled, addresses wrap at 256 bytes
`timescale 1ns/10ps

module mem_stage_tb;

    typedef struct packed {
        logic [2:0]                 kind;    // 0 sload 1 sstore 2 vload 3 vstore 4 vload+sload
        mem_stage_pkg::word_t       saddr;
        mem_stage_pkg::load_type_t  lt;
        mem_stage_pkg::word_t       wdata;
        mem_stage_pkg::vaddr_mode_t mode;
        mem_stage_pkg::word_t       base;
        mem_stage_pkg::word_t       stride;
        mem_stage_pkg::word_t [3:0] idx;
        mem_stage_pkg::word_t [3:0] vdata;
        mem_stage_pkg::lane_mask_t  mask;
    } test_t;

    logic CLK = 1'b0;
    logic rst_n, scalar_ren, scalar_wen, scalar_done, vstart, vload, vstore, vdone, mem_stall;
    logic dbus_ren, dbus_wen, dbus_busy;
    mem_stage_pkg::word_t scalar_addr, scalar_wdata, scalar_rdata, vbase, vstride;
    mem_stage_pkg::word_t dbus_addr, dbus_wdata, dbus_rdata;
    mem_stage_pkg::load_type_t scalar_load_type;
    mem_stage_pkg::vaddr_mode_t vmode;
    mem_stage_pkg::word_t [3:0] vindex, vstore_data, vwb_data;
    mem_stage_pkg::lane_mask_t vlane_mask, vwb_wen;
    mem_stage_pkg::word_t mem [64];
    logic [1:0] busy_left;
    int checks, errors, cycles;
    int total_errors;
    int limit = 1000;
    test_t tests[$];

    always #2 CLK = ~CLK;

    mem_stage dut_i (.*);
    mem_stage_checker chk_i (.*);
    bind mem_stage mem_stage_asserts asserts_i (.*);

    // Data bus memory model
    assign dbus_busy  = (dbus_ren || dbus_wen) && busy_left != 0;
    assign dbus_rdata = mem[dbus_addr[7:2]];
    always @(posedge CLK) begin
        if (dbus_ren || dbus_wen) begin
            if (busy_left != 0) busy_left <= busy_left - 1;
            else busy_left <= 2'($urandom % 3);   // Busy for the next access
            if (dbus_wen && busy_left == 0) mem[dbus_addr[7:2]] <= dbus_wdata;
        end
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: no done within %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic add(input logic [2:0] kind, input mem_stage_pkg::word_t saddr,
            input mem_stage_pkg::load_type_t lt, input mem_stage_pkg::vaddr_mode_t mode,
            input mem_stage_pkg::word_t stride, input mem_stage_pkg::lane_mask_t mask);
        test_t t;
        t = '{kind: kind, saddr: saddr, lt: lt, wdata: 32'h80f1_7f23, mode: mode,
              base: saddr, stride: stride, mask: mask,
              idx: {32'h1c, 32'h4, 32'h30, 32'h8},
              vdata: {32'hdead_0003, 32'h7e57_0002, 32'h0bad_0001, 32'hc0de_0000}};
        tests.push_back(t);
    endtask

    task automatic apply(input test_t t);
        @(posedge CLK);
        if (t.kind >= 2) begin
            {vstart, vload, vstore} <= {1'b1, t.kind != 3, t.kind == 3};
            {vmode, vbase, vstride, vlane_mask} <= {t.mode, t.base, t.stride, t.mask};
            {vindex, vstore_data} <= {t.idx, t.vdata};
        end
        if (t.kind < 2 || t.kind == 4) begin
            {scalar_ren, scalar_wen} <= {t.kind != 1, t.kind == 1};
            {scalar_addr, scalar_wdata, scalar_load_type} <= {t.saddr, t.wdata, t.lt};
            if (t.kind == 4) vbase <= 32'h0;   // Vector part reads a different block
        end
        @(posedge CLK);
        vstart <= 1'b0;
        if (t.kind == 2 || t.kind == 3) begin
            do @(negedge CLK); while (!vdone);
        end else begin
            do @(negedge CLK); while (!scalar_done);
            @(posedge CLK);
            {scalar_ren, scalar_wen} <= 2'b00;
        end
    endtask

    initial begin
        void'($urandom(32'hcc78_5ac9));
        {rst_n, scalar_ren, scalar_wen, vstart, vload, vstore, busy_left, cycles} = '0;
        {scalar_addr, scalar_wdata, scalar_load_type, vmode, vbase, vstride} = '0;
        {vindex, vstore_data, vlane_mask} = '0;
        for (int i = 0; i < 64; i++) mem[i] = (i * 32'h9e37_79b9) ^ {i[7:0], 24'h5a00c3};
        add(1, 32'h40, mem_stage_pkg::ld_lw, 0, 0, 0);
        for (int o = 0; o < 4; o++) begin
            add(0, 32'h40 + o, mem_stage_pkg::ld_lb, 0, 0, 0);
            add(0, 32'h40 + o, mem_stage_pkg::ld_lbu, 0, 0, 0);
            add(0, 32'h40 + (o & 2),
                (o & 1) ? mem_stage_pkg::ld_lhu : mem_stage_pkg::ld_lh, 0, 0, 0);
        end
        add(0, 32'h40, mem_stage_pkg::ld_lw, 0, 0, 0);
        add(3, 32'h80, 0, mem_stage_pkg::vm_unit, 0, 4'hf);
        add(2, 32'h80, 0, mem_stage_pkg::vm_unit, 0, 4'hf);
        add(2, 32'h10, 0, mem_stage_pkg::vm_strided, 12, 4'hf);
        add(2, 32'h20, 0, mem_stage_pkg::vm_indexed, 0, 4'hf);
        add(3, 32'ha0, 0, mem_stage_pkg::vm_unit, 0, 4'b0101);
        add(2, 32'ha0, 0, mem_stage_pkg::vm_unit, 0, 4'hf);
        add(2, 32'h60, 0, mem_stage_pkg::vm_strided, 8, 4'b1010);
        add(3, 32'hc0, 0, mem_stage_pkg::vm_unit, 0, 4'b0000);
        add(2, 32'hc0, 0, mem_stage_pkg::vm_unit, 0, 4'b0000);
        add(4, 32'h84, mem_stage_pkg::ld_lw, mem_stage_pkg::vm_unit, 0, 4'hf);
        limit = tests.size() * 4 * 5 + 50;
        repeat (2) @(posedge CLK);
        rst_n <= 1'b1;
        foreach (tests[i]) apply(tests[i]);
        repeat (2) @(negedge CLK);
        total_errors = errors + dut_i.asserts_i.fails;
        $display("Checks: %0d, errors: %0d", checks, total_errors);
        if (total_errors == 0 && checks == tests.size() + 1) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* filelist.f */
mem_stage_pkg.sv
lsc_if.sv
vmem_serializer.sv
mem_req_arbiter.sv
load_store_ctrl.sv
vlane_write_collect.sv
mem_stage.sv
mem_stage_asserts.sv
mem_stage_checker.sv
mem_stage_tb.sv
